/* src/freelist_pkg.sv */
/*
  Shared sizes and types for the 16-entry free-list tracker.
  Sizes are fixed here; modules take no parameters.
*/
package freelist_pkg;

  // Number of tracked entries handed out as buffer or tag IDs
  localparam int NUM_ENTRIES = 16;

  // Width of an entry ID
  localparam int ENTRY_ID_W = $clog2(NUM_ENTRIES);

  // Two independent deallocation ports, both accepted every cycle
  localparam int NUM_DEALLOC_PORTS = 2;

  // Count of 0 to NUM_DEALLOC_PORTS deallocations
  localparam int DEALLOC_COUNT_W = $clog2(NUM_DEALLOC_PORTS + 1);

  // Cycles from a sampled deallocation to its credit on dealloc_count
  localparam int CREDIT_DELAY = 2;

  // Entries 0 and 1 belong to the user out of reset
  localparam logic [NUM_ENTRIES-1:0] PREALLOCATED_ENTRIES = 16'h0003;

  // One entry number
  typedef logic [ENTRY_ID_W-1:0] entry_id_t;

  // One bit per entry
  typedef logic [NUM_ENTRIES-1:0] entry_vec_t;

  // Number of entries freed in one cycle
  typedef logic [DEALLOC_COUNT_W-1:0] dealloc_count_t;

  // Staging slot in front of the allocation port
  typedef enum logic {
    stage_empty = 1'b0,
    stage_full  = 1'b1
  } stage_state_e;

endpackage : freelist_pkg

/* src/free_vector.sv */
/*
  Free entries that are neither allocated nor staged.
  Deallocated IDs must name allocated entries, so set and clear never overlap.
*/
module free_vector import freelist_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  // Entries returned by the user this cycle
  input  entry_vec_t dealloc_onehot,
  // Entry the picker offers to the staging slot
  input  entry_vec_t pick_onehot,
  input  logic       pick_found,
  // Staging slot can take the picked entry this cycle
  input  logic       push_ready,
  output entry_vec_t free_entries
);

  entry_vec_t free_q;
  entry_vec_t free_d;
  entry_vec_t clear_mask;
  logic       push;

  // A push moves the picked entry out of the vector into the slot
  assign push = pick_found && push_ready;

  // Only the picked bit is cleared, and only on an actual push
  assign clear_mask = push ? pick_onehot : '0;

  // Freed entries join first, then the pushed entry leaves
  assign free_d = (free_q | dealloc_onehot) & ~clear_mask;

  // Out of reset every entry except the preallocated ones is free
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      free_q <= ~PREALLOCATED_ENTRIES;
    end else begin
      free_q <= free_d;
    end
  end

  // The picker sees the registered vector, so a freed entry is
  // visible one cycle after its deallocation is sampled
  assign free_entries = free_q;

endmodule : free_vector

/* src/free_entry_picker.sv */
/*
  Combinational pick of the lowest-index free entry.
  pick_id and pick_onehot are zero when nothing is free.
*/
module free_entry_picker import freelist_pkg::*; (
  input  entry_vec_t free_entries,
  output logic       pick_found,
  output entry_id_t  pick_id,
  output entry_vec_t pick_onehot
);

  entry_vec_t lowest_set;

  // Two's complement trick isolates the lowest set bit
  // The sum wraps at NUM_ENTRIES bits, which gives zero for an empty vector
  assign lowest_set = free_entries & (~free_entries + entry_vec_t'(1));

  assign pick_onehot = lowest_set;

  // Any free entry means there is something to offer
  assign pick_found = |free_entries;

  // One-hot to binary
  // Each ID bit is the OR of the one-hot bits whose index has that bit set
  always_comb begin
    pick_id = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (lowest_set[i]) begin
        pick_id = pick_id | entry_id_t'(i);
      end
    end
  end

endmodule : free_entry_picker

/* src/alloc_stage.sv */
/*
  One-entry forward staging register for the allocation port.
  An offered ID stays stable until it is taken, even if a lower entry frees up.
*/
module alloc_stage import freelist_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  // Picker side
  input  logic      pick_found,
  input  entry_id_t pick_id,
  output logic      push_ready,
  // User side, valid/ready
  output logic      alloc_valid,
  output entry_id_t alloc_entry_id,
  input  logic      alloc_ready
);

  stage_state_e state_q;
  stage_state_e state_d;
  entry_id_t    staged_id_q;
  logic         push;
  logic         pop;

  // Grant to the user happens when the slot is full and the user is ready
  assign pop = (state_q == stage_full) && alloc_ready;

  // The slot takes a new entry when empty, or when it drains this cycle
  assign push_ready = (state_q == stage_empty) || pop;

  assign push = pick_found && push_ready;

  // Push wins over pop, since a same-cycle pop leaves room for the new entry
  always_comb begin
    state_d = state_q;
    if (push) begin
      state_d = stage_full;
    end else if (pop) begin
      state_d = stage_empty;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= stage_empty;
    end else begin
      state_q <= state_d;
    end
  end

  // ID only loads on a push, which holds it under back-pressure
  always_ff @(posedge clk) begin
    if (push) begin
      staged_id_q <= pick_id;
    end
  end

  assign alloc_valid    = (state_q == stage_full);
  assign alloc_entry_id = staged_id_q;

endmodule : alloc_stage

/* src/dealloc_credit_return.sv */
/*
  Deallocation decode and credit return; dealloc_count lags by CREDIT_DELAY cycles.
  The two ports must not name the same entry in one cycle.
*/
module dealloc_credit_return import freelist_pkg::*; (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic      [NUM_DEALLOC_PORTS-1:0]      dealloc_valid,
  input  entry_id_t [NUM_DEALLOC_PORTS-1:0]      dealloc_entry_id,
  // Entries freed this cycle, straight to the free vector
  output entry_vec_t                             dealloc_onehot,
  // Credits for the user, delayed
  output dealloc_count_t                         dealloc_count
);

  dealloc_count_t count_now;
  dealloc_count_t count_pipe [CREDIT_DELAY];

  // Decode each valid port and merge, the ports write disjoint bits
  always_comb begin
    dealloc_onehot = '0;
    for (int p = 0; p < NUM_DEALLOC_PORTS; p++) begin
      if (dealloc_valid[p]) begin
        dealloc_onehot[dealloc_entry_id[p]] = 1'b1;
      end
    end
  end

  // Number of entries returned this cycle
  always_comb begin
    count_now = '0;
    for (int p = 0; p < NUM_DEALLOC_PORTS; p++) begin
      count_now = count_now + dealloc_count_t'(dealloc_valid[p]);
    end
  end

  // Shift register, stage 0 takes the fresh count
  // Count lines up with the entry reaching the staging slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < CREDIT_DELAY; s++) begin
        count_pipe[s] <= '0;
      end
    end else begin
      count_pipe[0] <= count_now;
      for (int s = 1; s < CREDIT_DELAY; s++) begin
        count_pipe[s] <= count_pipe[s-1];
      end
    end
  end

  assign dealloc_count = count_pipe[CREDIT_DELAY-1];

endmodule : dealloc_credit_return

/* src/freelist_tracker.sv */
/*
  Free-list tracker, 16 entries, one grant per cycle and two deallocations.
  Entries 0 and 1 are allocated out of reset; reuse and credit latency are 2 cycles.
*/
module freelist_tracker import freelist_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_n,
  // Allocation port, valid/ready
  output logic                              alloc_valid,
  input  logic                              alloc_ready,
  output entry_id_t                         alloc_entry_id,
  // Deallocation ports, always accepted
  input  logic      [NUM_DEALLOC_PORTS-1:0] dealloc_valid,
  input  entry_id_t [NUM_DEALLOC_PORTS-1:0] dealloc_entry_id,
  // Credits returned for freed entries
  output dealloc_count_t                    dealloc_count
);

  // Decoded deallocations into the free vector
  entry_vec_t dealloc_onehot;

  // Registered free vector into the picker
  entry_vec_t free_entries;

  // Picker result toward the staging slot
  logic       pick_found;
  entry_id_t  pick_id;
  entry_vec_t pick_onehot;

  // Slot accepts the pick this cycle
  logic       push_ready;

  dealloc_credit_return i_dealloc_credit_return (
    .clk              (clk),
    .rst_n            (rst_n),
    .dealloc_valid    (dealloc_valid),
    .dealloc_entry_id (dealloc_entry_id),
    .dealloc_onehot   (dealloc_onehot),
    .dealloc_count    (dealloc_count)
  );

  free_vector i_free_vector (
    .clk            (clk),
    .rst_n          (rst_n),
    .dealloc_onehot (dealloc_onehot),
    .pick_onehot    (pick_onehot),
    .pick_found     (pick_found),
    .push_ready     (push_ready),
    .free_entries   (free_entries)
  );

  free_entry_picker i_free_entry_picker (
    .free_entries (free_entries),
    .pick_found   (pick_found),
    .pick_id      (pick_id),
    .pick_onehot  (pick_onehot)
  );

  alloc_stage i_alloc_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .pick_found     (pick_found),
    .pick_id        (pick_id),
    .push_ready     (push_ready),
    .alloc_valid    (alloc_valid),
    .alloc_entry_id (alloc_entry_id),
    .alloc_ready    (alloc_ready)
  );

endmodule : freelist_tracker

/* tests/freelist_tracker_properties.sv */
/*
  Bound checks for the free-list tracker against a model of the allocated set.
  The model starts at PREALLOCATED_ENTRIES and follows grants and deallocations.
*/
module freelist_tracker_properties import freelist_pkg::*; (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              alloc_valid,
  input logic                              alloc_ready,
  input entry_id_t                         alloc_entry_id,
  input logic      [NUM_DEALLOC_PORTS-1:0] dealloc_valid,
  input entry_id_t [NUM_DEALLOC_PORTS-1:0] dealloc_entry_id,
  input dealloc_count_t                    dealloc_count
);

  // Failed assertions so far, read by the testbench
  int unsigned error_count = 0;

  entry_vec_t allocated_q;
  entry_vec_t freed_now;
  logic       grant;
  logic       first_cycle_q;
  // No deallocation seen yet, so grants must come out in ascending order
  logic       fresh_q;
  int         next_fresh_id;
  logic       stall_q;
  entry_id_t  stall_id_q;
  int         count_q1;
  int         count_q2;
  logic       reuse_now;
  entry_id_t  reuse_id_now;
  logic       reuse_q1;
  logic       reuse_q2;
  entry_id_t  reuse_id_q1;
  entry_id_t  reuse_id_q2;

  assign grant = alloc_valid && alloc_ready;

  always_comb begin
    freed_now = '0;
    for (int p = 0; p < NUM_DEALLOC_PORTS; p++) begin
      if (dealloc_valid[p]) begin
        freed_now[dealloc_entry_id[p]] = 1'b1;
      end
    end
  end

  // Lowest freed entry, the one to be offered first after exhaustion
  always_comb begin
    reuse_id_now = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (freed_now[i]) begin
        reuse_id_now = entry_id_t'(i);
      end
    end
  end

  // Every entry allocated means the free vector and the slot are empty
  assign reuse_now = (&allocated_q) && !alloc_valid && (|dealloc_valid);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      allocated_q   <= PREALLOCATED_ENTRIES;
      first_cycle_q <= 1'b1;
      fresh_q       <= 1'b1;
      // Entries 0 and 1 are taken, so the first grant is entry 2
      next_fresh_id <= 2;
      stall_q       <= 1'b0;
      stall_id_q    <= '0;
      count_q1      <= 0;
      count_q2      <= 0;
      reuse_q1      <= 1'b0;
      reuse_q2      <= 1'b0;
      reuse_id_q1   <= '0;
      reuse_id_q2   <= '0;
    end else begin
      allocated_q   <= (allocated_q & ~freed_now) |
                       (grant ? (entry_vec_t'(1) << alloc_entry_id) : '0);
      first_cycle_q <= 1'b0;
      if (|dealloc_valid) begin
        fresh_q <= 1'b0;
      end
      if (grant) begin
        next_fresh_id <= next_fresh_id + 1;
      end
      stall_q       <= alloc_valid && !alloc_ready;
      stall_id_q    <= alloc_entry_id;
      // Credits come back two edges after the deallocation is sampled
      count_q1      <= $countones(dealloc_valid);
      count_q2      <= count_q1;
      reuse_q1      <= reuse_now;
      reuse_q2      <= reuse_q1;
      reuse_id_q1   <= reuse_id_now;
      reuse_id_q2   <= reuse_id_q1;
    end
  end

  a_reset_valid: assert property (@(posedge clk) (!rst_n || first_cycle_q) |-> !alloc_valid)
    else begin
      error_count++;
      $error("[FAIL] %0t alloc_valid got %0d expected 0", $time, $sampled(alloc_valid));
    end

  // Also covers reset, where both sides are zero
  a_credit_count: assert property (@(posedge clk) int'(dealloc_count) == count_q2)
    else begin
      error_count++;
      $error("[FAIL] %0t dealloc_count got %0d expected %0d",
             $time, $sampled(dealloc_count), $sampled(count_q2));
    end

  a_fresh_order: assert property (@(posedge clk) disable iff (!rst_n)
      fresh_q && alloc_valid |-> int'(alloc_entry_id) == next_fresh_id)
    else begin
      error_count++;
      $error("[FAIL] %0t alloc_entry_id got %0d expected %0d",
             $time, $sampled(alloc_entry_id), $sampled(next_fresh_id));
    end

  a_fresh_exhausted: assert property (@(posedge clk) disable iff (!rst_n)
      fresh_q && next_fresh_id == NUM_ENTRIES |-> !alloc_valid)
    else begin
      error_count++;
      $error("[FAIL] %0t alloc_valid got %0d expected 0", $time, $sampled(alloc_valid));
    end

  a_grant_free: assert property (@(posedge clk) disable iff (!rst_n)
      grant |-> !allocated_q[alloc_entry_id])
    else begin
      error_count++;
      $error("grant of entry %0d which is already allocated", $sampled(alloc_entry_id));
    end

  a_dealloc0_held: assert property (@(posedge clk) disable iff (!rst_n)
      dealloc_valid[0] |-> allocated_q[dealloc_entry_id[0]])
    else begin
      error_count++;
      $error("dealloc port 0 freed entry %0d which is not allocated",
             $sampled(dealloc_entry_id[0]));
    end

  a_dealloc1_held: assert property (@(posedge clk) disable iff (!rst_n)
      dealloc_valid[1] |-> allocated_q[dealloc_entry_id[1]])
    else begin
      error_count++;
      $error("dealloc port 1 freed entry %0d which is not allocated",
             $sampled(dealloc_entry_id[1]));
    end

  a_dealloc_distinct: assert property (@(posedge clk) disable iff (!rst_n)
      &dealloc_valid |-> dealloc_entry_id[0] != dealloc_entry_id[1])
    else begin
      error_count++;
      $error("both dealloc ports named entry %0d in one cycle", $sampled(dealloc_entry_id[0]));
    end

  // Back-pressure holds the offer
  a_stall_valid: assert property (@(posedge clk) disable iff (!rst_n) stall_q |-> alloc_valid)
    else begin
      error_count++;
      $error("[FAIL] %0t alloc_valid got %0d expected 1", $time, $sampled(alloc_valid));
    end

  a_stall_id: assert property (@(posedge clk) disable iff (!rst_n)
      stall_q |-> alloc_entry_id == stall_id_q)
    else begin
      error_count++;
      $error("[FAIL] %0t alloc_entry_id got %0d expected %0d",
             $time, $sampled(alloc_entry_id), $sampled(stall_id_q));
    end

  a_reuse: assert property (@(posedge clk) disable iff (!rst_n)
      reuse_q2 |-> alloc_valid && alloc_entry_id == reuse_id_q2)
    else begin
      error_count++;
      $error("[FAIL] %0t alloc_entry_id got %0d (valid %0d) expected %0d", $time,
             $sampled(alloc_entry_id), $sampled(alloc_valid), $sampled(reuse_id_q2));
    end

endmodule : freelist_tracker_properties

/* tests/freelist_tracker_tb.sv */
/*
  Testbench for the free-list tracker; the bound property module does the checking.
  Stimulus only frees entries that it has seen granted or that are preallocated.
*/
module freelist_tracker_tb import freelist_pkg::*; ();

  localparam int CLK_PERIOD          = 100;
  localparam int RESET_CYCLES        = 3;
  localparam int RESET_PHASE_CYCLES  = RESET_CYCLES + 2;
  localparam int DRAIN_CYCLES        = 24;
  localparam int REUSE_ROUNDS        = 6;
  localparam int REUSE_CYCLES        = REUSE_ROUNDS * 5;
  localparam int BACKPRESSURE_CYCLES = 60;
  localparam int MIX_CYCLES          = 300;
  localparam int SETTLE_CYCLES       = 4;
  localparam int TIMEOUT_CYCLES      = RESET_PHASE_CYCLES + DRAIN_CYCLES + REUSE_CYCLES +
                                       BACKPRESSURE_CYCLES + MIX_CYCLES + SETTLE_CYCLES + 50;

  logic                              clk;
  logic                              rst_n;
  logic                              alloc_valid;
  logic                              alloc_ready;
  entry_id_t                         alloc_entry_id;
  logic      [NUM_DEALLOC_PORTS-1:0] dealloc_valid;
  entry_id_t [NUM_DEALLOC_PORTS-1:0] dealloc_entry_id;
  dealloc_count_t                    dealloc_count;

  logic [31:0] lfsr_state;
  // Entries the user side currently owns
  entry_vec_t  held;
  int          grant_count;
  int          cycle_count;
  int          phases_run;
  int          phases_failed;
  int          phase_start_errors;

  freelist_tracker i_freelist_tracker (
    .clk              (clk),
    .rst_n            (rst_n),
    .alloc_valid      (alloc_valid),
    .alloc_ready      (alloc_ready),
    .alloc_entry_id   (alloc_entry_id),
    .dealloc_valid    (dealloc_valid),
    .dealloc_entry_id (dealloc_entry_id),
    .dealloc_count    (dealloc_count)
  );

  bind freelist_tracker freelist_tracker_properties i_freelist_tracker_properties (
    .clk              (clk),
    .rst_n            (rst_n),
    .alloc_valid      (alloc_valid),
    .alloc_ready      (alloc_ready),
    .alloc_entry_id   (alloc_entry_id),
    .dealloc_valid    (dealloc_valid),
    .dealloc_entry_id (dealloc_entry_id),
    .dealloc_count    (dealloc_count)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [3:0] random_bits(input int width);
    logic [3:0] bits;
    logic       feedback;
    bits = '0;
    for (int i = 0; i < width; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      bits       = {bits[2:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic int assertion_failures();
    return int'(i_freelist_tracker.i_freelist_tracker_properties.error_count);
  endfunction

  // One clock of stimulus, applied on the falling edge
  task automatic drive_cycle(input logic ready, input logic [1:0] valid,
                             input entry_id_t id0, input entry_id_t id1);
    @(negedge clk);
    alloc_ready         = ready;
    dealloc_valid       = valid;
    dealloc_entry_id[0] = id0;
    dealloc_entry_id[1] = id1;
    if (valid[0]) begin
      held[id0] = 1'b0;
    end
    if (valid[1]) begin
      held[id1] = 1'b0;
    end
    // alloc_valid is settled here, so this predicts the grant at the next edge
    if (alloc_valid && ready) begin
      held[alloc_entry_id] = 1'b1;
      grant_count++;
    end
  endtask

  task automatic idle_cycle(input logic ready);
    drive_cycle(ready, 2'b00, '0, '0);
  endtask

  // Random frees, limited to held entries and to two different entries
  task automatic random_frees(output logic [1:0] valid, output entry_id_t id0,
                              output entry_id_t id1);
    logic want0;
    logic want1;
    want0    = random_bits(1) == 4'd1;
    id0      = entry_id_t'(random_bits(ENTRY_ID_W));
    want1    = random_bits(1) == 4'd1;
    id1      = entry_id_t'(random_bits(ENTRY_ID_W));
    valid[0] = want0 && held[id0];
    valid[1] = want1 && held[id1] && !(valid[0] && id1 == id0);
  endtask

  task automatic finish_phase(input string name);
    int errors;
    errors = assertion_failures() - phase_start_errors;
    phases_run++;
    if (errors == 0) begin
      $display("phase %s: ok", name);
    end else begin
      phases_failed++;
      $display("phase %s: %0d assertion failures", name, errors);
    end
    phase_start_errors = assertion_failures();
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : stimulus
    entry_id_t  id0;
    entry_id_t  id1;
    logic [1:0] valid;
    logic       pair;
    logic       ready;
    clk                = 1'b0;
    rst_n              = 1'b0;
    alloc_ready        = 1'b0;
    dealloc_valid      = '0;
    dealloc_entry_id   = '0;
    lfsr_state         = 32'h1402;
    held               = PREALLOCATED_ENTRIES;
    grant_count        = 0;
    phases_run         = 0;
    phases_failed      = 0;
    phase_start_errors = 0;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    idle_cycle(1'b0);
    idle_cycle(1'b0);
    finish_phase("reset");

    // Take every free entry with no deallocation in between
    grant_count = 0;
    while (grant_count < NUM_ENTRIES - $countones(PREALLOCATED_ENTRIES)) begin
      idle_cycle(1'b1);
    end
    repeat (4) idle_cycle(1'b1);
    finish_phase("drain");

    // Each round frees from a full tracker, odd rounds free a pair
    for (int round = 0; round < REUSE_ROUNDS; round++) begin
      id0  = entry_id_t'(random_bits(ENTRY_ID_W));
      id1  = entry_id_t'(random_bits(ENTRY_ID_W));
      pair = (round % 2 == 1) && (id1 != id0);
      drive_cycle(1'b1, {pair, 1'b1}, id0, id1);
      while (held != '1) begin
        idle_cycle(1'b1);
      end
    end
    finish_phase("exhausted reuse");

    drive_cycle(1'b0, 2'b11, 4'd12, 4'd5);
    repeat (6) idle_cycle(1'b0);
    // Entry 5 stays offered although entry 1 is lower
    drive_cycle(1'b0, 2'b01, 4'd1, 4'd0);
    repeat (4) idle_cycle(1'b0);
    while (held != '1) begin
      idle_cycle(random_bits(1) == 4'd1);
    end
    finish_phase("back-pressure");

    repeat (MIX_CYCLES) begin
      ready = random_bits(1) == 4'd1;
      random_frees(valid, id0, id1);
      drive_cycle(ready, valid, id0, id1);
    end
    repeat (SETTLE_CYCLES) idle_cycle(1'b0);
    finish_phase("random mix");

    $display("phases run %0d, phases failed %0d, assertion failures %0d",
             phases_run, phases_failed, assertion_failures());
    if (phases_failed == 0 && assertion_failures() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : freelist_tracker_tb

/* freelist_tracker.f */
src/freelist_pkg.sv
src/free_vector.sv
src/free_entry_picker.sv
src/alloc_stage.sv
src/dealloc_credit_return.sv
src/freelist_tracker.sv
tests/freelist_tracker_properties.sv
tests/freelist_tracker_tb.sv

/* run.sh */
#!/bin/sh
# Builds the free-list tracker testbench with Verilator and runs it.
# Exits non-zero unless the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
    --top-module freelist_tracker_tb \
    --Mdir "$BUILD_DIR" \
    -f freelist_tracker.f; then
  echo "verilator build failed"
  exit 1
fi

# Raise the error limit so that every failed assertion is reported
"./$BUILD_DIR/Vfreelist_tracker_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
